// ==== rtl/proc_pkg.sv ====
package proc_pkg;

    //////////////////////////////
    // widths and sizes
    //////////////////////////////

    localparam int xlen            = 32;   // address / pc width
    localparam int icache_lines    = 16;   // 8 byte lines, direct mapped
    localparam int icache_idx_bits = 4;    // index = addr[6:3], tag = addr[31:7]
    localparam int mem_tag_bits    = 4;    // zero tag means none
    localparam int miss_timeout    = 64;   // cycles before a lost reply is reissued

    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;  // first fetch
    localparam logic [31:0]     wfi_inst = 32'h1050_0073;  // rv32 wfi encoding

    //////////////////////////////
    // encodings
    //////////////////////////////

    // memory command, same values as the memory model expects
    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_cmd_e;

    typedef enum logic [1:0] {
        byte_size   = 2'h0,
        half_size   = 2'h1,
        word_size   = 2'h2,
        double_size = 2'h3   // whole cache line
    } mem_size_e;

    typedef enum logic [1:0] {
        no_error      = 2'h0,
        illegal_inst  = 2'h1,
        halted_on_wfi = 2'h2
    } error_code_e;

    typedef enum logic [1:0] {
        inst_normal,
        inst_wfi,
        inst_illegal
    } inst_class_e;

    typedef enum logic [1:0] {
        st_idle,         // lookup only
        st_request,      // first issue of the load
        st_wait_tag,     // memory busy, load held and retried
        st_wait_data     // accepted, watching for our tag
    } icache_state_e;

endpackage

// ==== rtl/icache_mem.sv ====
`timescale 1ns/1ps

module icache_mem (
    input  logic                                              clock,
    input  logic                                              arst_n,
    input  logic [proc_pkg::xlen-1:0]                         fetch_addr,
    input  logic                                              fetch_valid,
    input  logic                                              fill_valid,
    input  logic [proc_pkg::icache_idx_bits-1:0]              fill_idx,
    input  logic [proc_pkg::xlen-1:proc_pkg::icache_idx_bits+3] fill_tag,
    input  logic [63:0]                                       fill_data,
    output logic                                              hit,
    output logic [63:0]                                       line_data
);
    import proc_pkg::*;

    // storage
    logic [icache_lines-1:0]          valid;
    logic [xlen-1:icache_idx_bits+3]  tag_array  [icache_lines];
    logic [63:0]                      data_array [icache_lines];

    // lookup fields
    logic [icache_idx_bits-1:0]       rd_idx;
    logic [xlen-1:icache_idx_bits+3]  rd_tag;

    assign rd_idx = fetch_addr[icache_idx_bits+2:3];   // bits 6..3
    assign rd_tag = fetch_addr[xlen-1:icache_idx_bits+3];

    //////////////////////////////
    // lookup, purely combinational
    //////////////////////////////

    assign hit       = fetch_valid && valid[rd_idx] && (tag_array[rd_idx] == rd_tag);
    assign line_data = data_array[rd_idx];   // meaningful only with hit

    //////////////////////////////
    // fill
    //////////////////////////////

    // valid bits: cleared on reset, set by a fill
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
        end else if (fill_valid) begin
            valid[fill_idx] <= 1'b1;
        end
    end

    // whole line written at once
    always_ff @(posedge clock) begin
        if (fill_valid) begin
            tag_array[fill_idx]  <= fill_tag;
            data_array[fill_idx] <= fill_data;   // replaces any older line here
        end
    end

endmodule

// ==== rtl/icache_ctrl.sv ====
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                                                clock,
    input  logic                                                arst_n,
    input  logic [proc_pkg::xlen-1:0]                           fetch_addr,
    input  logic                                                fetch_valid,
    input  logic                                                hit,
    input  logic [proc_pkg::mem_tag_bits-1:0]                   mem2proc_response,
    input  logic [proc_pkg::mem_tag_bits-1:0]                   mem2proc_tag,
    input  logic [63:0]                                         mem2proc_data,
    input  logic                                                timer_expired,
    output proc_pkg::bus_cmd_e                                  proc2mem_command,
    output logic [proc_pkg::xlen-1:0]                           proc2mem_addr,
    output logic                                                fill_valid,
    output logic [proc_pkg::icache_idx_bits-1:0]                fill_idx,
    output logic [proc_pkg::xlen-1:proc_pkg::icache_idx_bits+3] fill_tag,
    output logic [63:0]                                         fill_data,
    output logic                                                timer_run
);
    import proc_pkg::*;

    icache_state_e           state;
    icache_state_e           state_nxt;
    logic [xlen-1:3]         miss_line;   // line address of the outstanding miss
    logic [mem_tag_bits-1:0] mem_tag;     // tag handed back by memory
    logic                    issuing;     // load on the bus this cycle
    logic                    accepted;
    logic                    tag_match;

    assign issuing   = (state == st_request) || (state == st_wait_tag);
    assign accepted  = issuing && (mem2proc_response != '0);   // zero = busy
    assign tag_match = (mem_tag != '0) && (mem2proc_tag == mem_tag);

    //////////////////////////////
    // miss fsm
    //////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (fetch_valid && !hit) begin
                    state_nxt = st_request;   // load goes out next cycle
                end
            end
            st_request, st_wait_tag: begin
                // busy memory, keep the load up and retry
                state_nxt = accepted ? st_wait_data : st_wait_tag;
            end
            st_wait_data: begin
                if (tag_match) begin
                    state_nxt = st_idle;      // line lands at this edge
                end else if (timer_expired) begin
                    state_nxt = st_request;   // reply lost, ask again
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state   <= st_idle;
            mem_tag <= '0;
        end else begin
            state <= state_nxt;
            if (accepted) begin
                mem_tag <= mem2proc_response;   // remember which reply is ours
            end else if (fill_valid) begin
                mem_tag <= '0;                  // nothing outstanding
            end
        end
    end

    // line address of the miss
    always_ff @(posedge clock) begin
        if (state == st_idle && fetch_valid && !hit) begin
            miss_line <= fetch_addr[xlen-1:3];
        end
    end

    //////////////////////////////
    // memory side and fill
    //////////////////////////////

    assign proc2mem_command = issuing ? bus_load : bus_none;
    assign proc2mem_addr    = {miss_line, 3'b000};   // always line aligned

    // other tags are stale or foreign, ignored
    assign fill_valid = (state == st_wait_data) && tag_match;
    assign fill_idx   = miss_line[icache_idx_bits+2:3];
    assign fill_tag   = miss_line[xlen-1:icache_idx_bits+3];
    assign fill_data  = mem2proc_data;

    assign timer_run = (state == st_wait_data);   // only while a reply is owed

endmodule

// ==== rtl/miss_timer.sv ====
`timescale 1ns/1ps

module miss_timer (
    input  logic clock,
    input  logic arst_n,
    input  logic timer_run,
    output logic timer_expired
);
    import proc_pkg::*;

    logic [$clog2(miss_timeout)-1:0] count;   // 0 .. miss_timeout-1

    // counts up while run is high, restarts whenever it drops
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count         <= '0;
            timer_expired <= 1'b0;
        end else if (!timer_run) begin
            count         <= '0;
            timer_expired <= 1'b0;
        end else if (count == miss_timeout - 1) begin
            count         <= '0;
            timer_expired <= 1'b1;   // one cycle pulse
        end else begin
            count         <= count + 1'b1;
            timer_expired <= 1'b0;
        end
    end

endmodule

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      hit,
    input  logic [63:0]               line_data,
    input  logic                      inst_ack,
    input  logic                      redirect_valid,
    input  logic [proc_pkg::xlen-1:0] redirect_pc,
    output logic [proc_pkg::xlen-1:0] fetch_addr,
    output logic                      fetch_valid,
    output logic                      inst_req,
    output logic [31:0]               inst,
    output logic [proc_pkg::xlen-1:0] inst_pc,
    output proc_pkg::error_code_e     error_status
);
    import proc_pkg::*;

    logic [xlen-1:0] pc;
    logic            pend_valid;   // redirect waiting for a free slot
    logic [xlen-1:0] pend_pc;
    logic            slot_free;    // no handshake open
    logic [31:0]     word;
    inst_class_e     word_class;
    logic            take;         // line hit for the current pc

    //////////////////////////////
    // lookup request
    //////////////////////////////

    // req low and ack seen low, so a new req may rise
    assign slot_free  = !inst_req && !inst_ack;
    assign fetch_addr = pc;
    // no fetch while a redirect is pending or halted
    assign fetch_valid = slot_free && !pend_valid && !redirect_valid
                         && (error_status == no_error);
    assign take = fetch_valid && hit;

    // pick the word by pc[2] and class it
    assign word = pc[2] ? line_data[63:32] : line_data[31:0];

    always_comb begin
        if (word == wfi_inst) begin
            word_class = inst_wfi;
        end else if ((word[1:0] != 2'b11) || (word == '0)) begin
            word_class = inst_illegal;
        end else begin
            word_class = inst_normal;
        end
    end

    //////////////////////////////
    // pc, handshake, status
    //////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc           <= reset_pc;
            pend_valid   <= 1'b0;
            inst_req     <= 1'b0;
            error_status <= no_error;
        end else begin
            // newest redirect wins, applied once the slot is free
            if (redirect_valid) begin
                pend_valid <= 1'b1;
            end else if (slot_free && pend_valid) begin
                pend_valid <= 1'b0;
                pc         <= pend_pc;
            end

            if (inst_req && inst_ack) begin
                inst_req <= 1'b0;            // phase 2, wait for ack to fall
            end else if (take && word_class == inst_normal) begin
                inst_req <= 1'b1;
                pc       <= pc + 32'd4;      // then held under back-pressure
            end

            // sticky until reset, never delivered
            if (take && word_class == inst_wfi) begin
                error_status <= halted_on_wfi;
            end else if (take && word_class == inst_illegal) begin
                error_status <= illegal_inst;
            end
        end
    end

    // payload, stable while req is high
    always_ff @(posedge clock) begin
        if (redirect_valid) begin
            pend_pc <= redirect_pc;
        end
        if (take && word_class == inst_normal) begin
            inst    <= word;
            inst_pc <= pc;
        end
    end

endmodule

// ==== rtl/processor.sv ====
`timescale 1ns/1ps

module processor (
    input  logic                                clock,
    input  logic                                arst_n,
    input  logic [proc_pkg::mem_tag_bits-1:0]   mem2proc_response,  // accept tag, 0 = busy
    input  logic [proc_pkg::mem_tag_bits-1:0]   mem2proc_tag,       // tag of returning data
    input  logic [63:0]                         mem2proc_data,
    input  logic                                inst_ack,
    input  logic                                redirect_valid,     // one cycle strobe
    input  logic [proc_pkg::xlen-1:0]           redirect_pc,
    output proc_pkg::bus_cmd_e                  proc2mem_command,
    output logic [proc_pkg::xlen-1:0]           proc2mem_addr,
    output logic [63:0]                         proc2mem_data,
    output proc_pkg::mem_size_e                 proc2mem_size,
    output logic                                inst_req,
    output logic [31:0]                         inst,
    output logic [proc_pkg::xlen-1:0]           inst_pc,
    output proc_pkg::error_code_e               error_status
);
    import proc_pkg::*;

    // fetch <-> cache
    logic [xlen-1:0]                  fetch_addr;
    logic                             fetch_valid;
    logic                             hit;
    logic [63:0]                      line_data;

    // controller -> arrays
    logic                             fill_valid;
    logic [icache_idx_bits-1:0]       fill_idx;
    logic [xlen-1:icache_idx_bits+3]  fill_tag;
    logic [63:0]                      fill_data;

    logic                             timer_run;
    logic                             timer_expired;

    // fetch only reads whole lines
    assign proc2mem_size = double_size;
    assign proc2mem_data = 64'h0;

    //////////////////////////////
    // fetch
    //////////////////////////////

    fetch_stage i_fetch_stage (
        .clock          (clock),
        .arst_n         (arst_n),
        .hit            (hit),
        .line_data      (line_data),
        .inst_ack       (inst_ack),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_addr     (fetch_addr),
        .fetch_valid    (fetch_valid),
        .inst_req       (inst_req),
        .inst           (inst),
        .inst_pc        (inst_pc),
        .error_status   (error_status)
    );

    //////////////////////////////
    // icache
    //////////////////////////////

    icache_mem i_icache_mem (
        .clock       (clock),
        .arst_n      (arst_n),
        .fetch_addr  (fetch_addr),
        .fetch_valid (fetch_valid),
        .fill_valid  (fill_valid),
        .fill_idx    (fill_idx),
        .fill_tag    (fill_tag),
        .fill_data   (fill_data),
        .hit         (hit),
        .line_data   (line_data)
    );

    icache_ctrl i_icache_ctrl (
        .clock             (clock),
        .arst_n            (arst_n),
        .fetch_addr        (fetch_addr),
        .fetch_valid       (fetch_valid),
        .hit               (hit),
        .mem2proc_response (mem2proc_response),
        .mem2proc_tag      (mem2proc_tag),
        .mem2proc_data     (mem2proc_data),
        .timer_expired     (timer_expired),
        .proc2mem_command  (proc2mem_command),
        .proc2mem_addr     (proc2mem_addr),
        .fill_valid        (fill_valid),
        .fill_idx          (fill_idx),
        .fill_tag          (fill_tag),
        .fill_data         (fill_data),
        .timer_run         (timer_run)
    );

    miss_timer i_miss_timer (
        .clock         (clock),
        .arst_n        (arst_n),
        .timer_run     (timer_run),
        .timer_expired (timer_expired)   // back to st_request on this
    );

endmodule

// ==== verification/processor_chk.sv ====
`timescale 1ns/1ps

module processor_chk (
    input logic                      clock,
    input logic                      arst_n,
    input logic                      inst_req,
    input logic                      inst_ack,
    input logic [31:0]               inst,
    input logic [proc_pkg::xlen-1:0] inst_pc,
    input proc_pkg::error_code_e     error_status,
    input proc_pkg::bus_cmd_e        proc2mem_command,
    input logic [proc_pkg::xlen-1:0] proc2mem_addr
);
    import proc_pkg::*;

    int fail_count = 0;   // failed assertions so far

    // payload frozen from req until the back end acks
    assert property (@(posedge clock) disable iff (!arst_n)
        inst_req && !inst_ack |=> $stable(inst) && $stable(inst_pc))
        else begin
            $error("inst or inst_pc changed while waiting for inst_ack");
            fail_count++;
        end

    // halt status is sticky
    assert property (@(posedge clock) disable iff (!arst_n)
        error_status != no_error |=> error_status != no_error)
        else begin
            $error("error_status went back to no_error without reset");
            fail_count++;
        end

    // fills are whole lines
    assert property (@(posedge clock) disable iff (!arst_n)
        proc2mem_command == bus_load |-> proc2mem_addr[2:0] == 3'b000)
        else begin
            $error("load address not line aligned");
            fail_count++;
        end

endmodule

bind processor processor_chk i_processor_chk (
    .clock            (clock),
    .arst_n           (arst_n),
    .inst_req         (inst_req),
    .inst_ack         (inst_ack),
    .inst             (inst),
    .inst_pc          (inst_pc),
    .error_status     (error_status),
    .proc2mem_command (proc2mem_command),
    .proc2mem_addr    (proc2mem_addr)
);

// ==== verification/processor_tb.sv ====
`timescale 1ns/1ps

module processor_tb;
    import proc_pkg::*;

    logic                    clock;
    logic                    arst_n;
    logic [mem_tag_bits-1:0] mem2proc_response;
    logic [mem_tag_bits-1:0] mem2proc_tag;
    logic [63:0]             mem2proc_data;
    logic                    inst_ack;
    logic                    redirect_valid;
    logic [xlen-1:0]         redirect_pc;
    bus_cmd_e                proc2mem_command;
    logic [xlen-1:0]         proc2mem_addr;
    logic [63:0]             proc2mem_data;
    mem_size_e               proc2mem_size;
    logic                    inst_req;
    logic [31:0]             inst;
    logic [xlen-1:0]         inst_pc;
    error_code_e             error_status;

    logic [63:0]     image [int unsigned];   // line address -> line
    logic [xlen-1:0] step_tgt [$];
    bit              step_jump [$];
    int              step_cnt [$];
    int              step_halt [$];
    logic [xlen-1:0] all_pcs [$];
    logic [xlen-1:0] exp_pcs [$];            // stream the back end expects next

    int              n_checks;
    int              n_errors;
    bit              cases_loaded;
    bit              skip_open;              // request raised before a redirect
    bit              req_checked;
    int              ack_wait;
    logic [31:0]     held_inst;
    logic [xlen-1:0] held_pc;

    // memory model state
    bit                              reply_pending;
    int                              reply_wait;
    logic [mem_tag_bits-1:0]         reply_tag;
    logic [xlen-1:0]                 reply_addr;
    logic [mem_tag_bits-1:0]         next_tag;
    bit                              model_valid [icache_lines];   // own copy of the tags
    logic [xlen-1:icache_idx_bits+3] model_tag [icache_lines];

    processor i_processor (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [63:0] line_at(logic [xlen-1:0] addr);
        logic [xlen-1:0] a;
        a = {addr[xlen-1:3], 3'b000};
        if (image.exists(a)) begin
            return image[a];
        end
        return {~a | 32'h3, a | 32'h3};   // lines not listed, still normal words
    endfunction

    function automatic logic [31:0] word_at(logic [xlen-1:0] pc);
        logic [63:0] line;
        line = line_at(pc);
        return pc[2] ? line[63:32] : line[31:0];
    endfunction

    //////////////////////////////
    // memory model
    //////////////////////////////

    always @(posedge clock) begin : mem_model
        logic [icache_idx_bits-1:0] idx;
        if (!arst_n) begin
            reply_pending = 1'b0;
            next_tag      = 4'h1;
            mem2proc_tag      <= 4'h0;
            mem2proc_response <= 4'h0;
            for (int i = 0; i < icache_lines; i++) begin
                model_valid[i] = 1'b0;
            end
        end else begin
            if (reply_pending && reply_wait == 0) begin
                mem2proc_tag  <= reply_tag;
                mem2proc_data <= line_at(reply_addr);
                idx = reply_addr[icache_idx_bits+2:3];
                model_valid[idx] = 1'b1;   // line lands at the next edge
                model_tag[idx]   = reply_addr[xlen-1:icache_idx_bits+3];
                reply_pending    = 1'b0;
            end else begin
                mem2proc_tag <= 4'h0;
                if (reply_pending) begin
                    reply_wait--;
                end
            end
            // load seen with a nonzero response, accepted
            if (proc2mem_command == bus_load && mem2proc_response != 4'h0) begin
                n_checks++;
                idx = proc2mem_addr[icache_idx_bits+2:3];
                if (proc2mem_addr[2:0] != 3'b000) begin
                    $display("Fail proc2mem_addr: expected %h, got %h",
                             {proc2mem_addr[xlen-1:3], 3'b000}, proc2mem_addr);
                    n_errors++;
                end
                if (proc2mem_size != double_size) begin
                    $display("Fail proc2mem_size: expected %h, got %h", double_size, proc2mem_size);
                    n_errors++;
                end
                if (proc2mem_data !== 64'h0) begin
                    $display("Fail proc2mem_data: expected %h, got %h", 64'h0, proc2mem_data);
                    n_errors++;
                end
                if (model_valid[idx]
                    && model_tag[idx] == proc2mem_addr[xlen-1:icache_idx_bits+3]) begin
                    $display("load issued for line %h, which is still in the cache", proc2mem_addr);
                    n_errors++;
                end
                if ($urandom_range(15) != 0) begin   // about one in sixteen lost
                    reply_pending = 1'b1;
                    reply_wait    = $urandom_range(11);
                    reply_tag     = mem2proc_response;
                    reply_addr    = proc2mem_addr;
                end
                next_tag = (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
            end
            mem2proc_response <= ($urandom_range(3) == 0) ? 4'h0 : next_tag;   // busy at random
        end
    end

    //////////////////////////////
    // back end
    //////////////////////////////

    task automatic check_delivery(input logic [xlen-1:0] exp_pc);
        n_checks++;
        if (inst_pc !== exp_pc) begin
            $display("Fail inst_pc: expected %h, got %h", exp_pc, inst_pc);
            n_errors++;
        end
        if (inst !== word_at(exp_pc)) begin
            $display("Fail inst: expected %h, got %h", word_at(exp_pc), inst);
            n_errors++;
        end
    endtask

    always @(posedge clock) begin
        if (!arst_n) begin
            inst_ack    <= 1'b0;
            req_checked = 1'b0;
        end else if (inst_ack) begin
            if (!inst_req) begin
                inst_ack    <= 1'b0;   // req dropped, close the handshake
                req_checked = 1'b0;
            end
        end else if (inst_req) begin
            // stalls while nothing is expected
            if (!req_checked && (skip_open || exp_pcs.size() > 0)) begin
                if (skip_open) begin
                    skip_open = 1'b0;
                end else begin
                    check_delivery(exp_pcs.pop_front());
                end
                req_checked = 1'b1;
                held_inst   = inst;
                held_pc     = inst_pc;
                ack_wait    = $urandom_range(5);
            end
            if (req_checked) begin
                if (inst !== held_inst || inst_pc !== held_pc) begin
                    $display("Fail inst_pc/inst: held %h/%h, now %h/%h",
                             held_pc, held_inst, inst_pc, inst);
                    n_errors++;
                end
                if (ack_wait == 0) begin
                    inst_ack <= 1'b1;
                end else begin
                    ack_wait--;
                end
            end
        end
    end

    //////////////////////////////
    // cases and steps
    //////////////////////////////

    task automatic load_cases();
        int              fd;
        int              code;
        string           kw;
        string           tgt_s;
        string           rest;
        logic [xlen-1:0] addr;
        logic [63:0]     data;
        int              cnt;
        int              halt;
        fd = $fopen("verification/fetch_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/fetch_cases.txt");
            n_errors++;
            return;
        end
        while ($fscanf(fd, "%s", kw) == 1) begin
            if (kw == "m") begin
                code = $fscanf(fd, "%h %h", addr, data);
                image[addr] = data;
            end else if (kw == "s") begin
                code = $fscanf(fd, "%s %d %d", tgt_s, cnt, halt);
                step_jump.push_back(tgt_s != "-");
                code = $sscanf(tgt_s, "%h", addr);
                step_tgt.push_back(addr);
                step_cnt.push_back(cnt);
                step_halt.push_back(halt);
            end else if (kw == "p") begin
                code = $fscanf(fd, "%h", addr);
                all_pcs.push_back(addr);
            end else begin
                code = $fgets(rest, fd);   // comment, rest of the line
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_reset();
        @(posedge clock);
        arst_n <= 1'b0;
        repeat (8) @(posedge clock);
        arst_n <= 1'b1;
        skip_open = 1'b0;
    endtask

    task automatic run_step();
        logic [xlen-1:0] tgt;
        bit              jump;
        int              cnt;
        int              halt;
        int              waited;
        bit              req_seen;
        tgt  = step_tgt.pop_front();
        jump = step_jump.pop_front();
        cnt  = step_cnt.pop_front();
        halt = step_halt.pop_front();
        if (jump) begin
            @(posedge clock);
            redirect_valid <= 1'b1;
            redirect_pc    <= tgt;
            @(posedge clock);
            redirect_valid <= 1'b0;
        end
        @(negedge clock);
        // a stalled request still up here predates the strobe
        skip_open = jump && inst_req && !req_checked;
        repeat (cnt) exp_pcs.push_back(all_pcs.pop_front());
        while (exp_pcs.size() > 0 || skip_open || req_checked || inst_ack) begin
            @(negedge clock);
        end
        if (halt != 0) begin
            waited = 0;
            while (error_status == no_error && waited < 4 * (miss_timeout + 40)) begin
                @(negedge clock);
                waited++;
            end
            n_checks++;
            if (error_status != error_code_e'(halt)) begin
                $display("Fail error_status: expected %h, got %h",
                         error_code_e'(halt), error_status);
                n_errors++;
            end
            req_seen = 1'b0;
            repeat (16) begin
                @(negedge clock);
                req_seen = req_seen | inst_req;
            end
            if (req_seen) begin
                $display("instruction request raised after fetch halted");
                n_errors++;
            end
            apply_reset();
        end else if (error_status != no_error) begin
            $display("Fail error_status: expected %h, got %h", no_error, error_status);
            n_errors++;
        end
    endtask

    initial begin
        void'($urandom(32'he0a8bf34));
        arst_n            = 1'b0;
        mem2proc_response = 4'h0;
        mem2proc_tag      = 4'h0;
        mem2proc_data     = 64'h0;
        inst_ack          = 1'b0;
        redirect_valid    = 1'b0;
        redirect_pc       = '0;
        n_checks          = 0;
        n_errors          = 0;
        skip_open         = 1'b0;
        load_cases();
        cases_loaded = 1'b1;
        repeat (8) @(posedge clock);
        arst_n <= 1'b1;
        while (step_cnt.size() > 0) begin
            run_step();
        end
        // failed bound assertions count as errors too
        n_errors += i_processor.i_processor_chk.fail_count;
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog, scaled by the number of instructions and steps
    initial begin
        int limit;
        wait (cases_loaded);
        limit = (all_pcs.size() + 2 * step_cnt.size() + 2) * (miss_timeout + 40) * 8;
        #(limit);
        $display("run did not finish within %0d ns", limit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== build.f ====
rtl/proc_pkg.sv
rtl/icache_mem.sv
rtl/icache_ctrl.sv
rtl/miss_timer.sv
rtl/fetch_stage.sv
rtl/processor.sv
verification/processor_chk.sv
verification/processor_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - files:
      - rtl/proc_pkg.sv
      - rtl/icache_mem.sv
      - rtl/icache_ctrl.sv
      - rtl/miss_timer.sv
      - rtl/fetch_stage.sv
      - rtl/processor.sv
  - target: test
    files:
      - verification/processor_chk.sv
      - verification/processor_tb.sv

// ==== verification/fetch_cases.txt ====
# m <line addr> <line, upper word is addr+4>            memory image, hex
# s <redirect target or -> <count> <halt 0 none 1 illegal 2 wfi>, then <count> lines p <pc>
m 00000000 0020811300100093
m 00000008 003101b300418193
m 00000010 0041022300520293
m 00000018 0062833300730393
m 00000020 1050007300838413
m 00000040 00a5051300948493
m 00000048 00c6061300b58593
m 00000080 00e7071300d68693
m 00000088 0000000000f78793
s - 6 0
p 00000000 p 00000004 p 00000008 p 0000000c p 00000010 p 00000014
s 00000008 3 0
p 00000008 p 0000000c p 00000010
s 00000080 2 0
p 00000080 p 00000084
s 00000000 4 0
p 00000000 p 00000004 p 00000008 p 0000000c
s 00000040 2 0
p 00000040 p 00000044
s - 2 0
p 00000048 p 0000004c
s 00000018 3 2
p 00000018 p 0000001c p 00000020
s 00000080 3 1
p 00000080 p 00000084 p 00000088
